// File: hist_tests.txt
# columns: H pixel bin | B pixel bin (hit with acq_end) | A | R pixel bin n
# G n idle cycles | P lane bin count, expected peak in report order
# frame 1, spread hits, tie in lane 1, empty lane 2, pixel 6 dropped
H 0 3
H 1 9
A
H 0 5
H 6 3
A
H 0 3
H 1 4
A
H 3 12
A
P 0 3 2
P 1 4 1
P 2 0 0
P 3 12 1
# frame 2, starts while frame 1 drains, saturation in lane 3
H 2 8
H 2 8
R 3 6 260
A
H 0 10
A
H 4 8
A
B 1 1
P 0 10 1
P 1 1 1
P 2 8 2
P 3 6 255
# frame 3 reuses the cleared first bank, pixel 7 dropped
G 24
H 0 7
H 7 2
A
A
A
A
P 0 7 1
P 1 0 0
P 2 0 0
P 3 0 0

// File: sim.f
hist_pkg.sv
hist_dispatch.sv
hist_lane.sv
peak_readout.sv
hist_top.sv
tb_hist.sv

// File: Makefile
# Verilator build for the histogram subsystem

VERILATOR  ?= verilator
TB_TOP     ?= tb_hist
RTL_TOP    ?= hist_top
FLIST      ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
RTL_SRCS   ?= hist_pkg.sv hist_dispatch.sv hist_lane.sv peak_readout.sv hist_top.sv
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= Simulation finished: FAIL
PASS_MSG   ?= Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_hist.sv
`timescale 1ns/1ps

module tb_hist import hist_pkg::*; ();

    localparam int NUM_LANES  = DEF_NUM_LANES;
    localparam int BIN_BITS   = DEF_BIN_BITS;
    localparam int COUNT_BITS = DEF_COUNT_BITS;
    localparam int ACQ_NUM    = DEF_ACQ_NUM;
    localparam int LANE_BITS  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int NUM_BINS   = 2 ** BIN_BITS;
    localparam int COUNT_MAX  = 2 ** COUNT_BITS - 1;
    localparam int STIM_DLY   = 1;
    localparam int SEED       = 32'h40b1_7851;
    // first report comes 2 + NUM_BINS cycles after the closing strobe
    localparam int PEAK_TIMEOUT  = 2 * NUM_BINS + 8;
    localparam int DRAIN_TIMEOUT = 4 * (NUM_BINS + NUM_LANES) + 16;

    logic                  clk;
    logic                  res;
    logic                  hit;
    logic [LANE_BITS:0]    hit_pixel;
    logic [BIN_BITS-1:0]   hit_bin;
    logic                  acq_end;
    logic                  his_num;
    logic                  peak_valid;
    logic [LANE_BITS-1:0]  peak_lane;
    logic [BIN_BITS-1:0]   peak_bin;
    logic [COUNT_BITS-1:0] peak_count;

    // reference model, two banks per lane
    int   model_mem [2][NUM_LANES][NUM_BINS];
    int   model_sel;
    int   model_acq_cnt;
    logic exp_his;

    // peaks from the model, in report order
    int exp_lane[$];
    int exp_bin[$];
    int exp_count[$];
    // peaks from the P lines of the test file
    int file_lane[$];
    int file_bin[$];
    int file_count[$];

    hist_top #(
        .NUM_LANES  (NUM_LANES),
        .BIN_BITS   (BIN_BITS),
        .COUNT_BITS (COUNT_BITS),
        .ACQ_NUM    (ACQ_NUM)
    ) u_dut (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_pixel  (hit_pixel),
        .hit_bin    (hit_bin),
        .acq_end    (acq_end),
        .his_num    (his_num),
        .peak_valid (peak_valid),
        .peak_lane  (peak_lane),
        .peak_bin   (peak_bin),
        .peak_count (peak_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // saturating count, out of range pixels ignored
    task automatic model_hit(input int pix, input int bin);
        if (pix < NUM_LANES && model_mem[model_sel][pix][bin] < COUNT_MAX) begin
            model_mem[model_sel][pix][bin]++;
        end
    endtask

    // peaks of the closed bank, then clear it and flip
    task automatic model_close_frame();
        int best;
        int best_b;
        for (int l = 0; l < NUM_LANES; l++) begin
            best   = 0;
            best_b = 0;
            for (int b = 0; b < NUM_BINS; b++) begin
                // lowest bin keeps a tie
                if (model_mem[model_sel][l][b] > best) begin
                    best   = model_mem[model_sel][l][b];
                    best_b = b;
                end
                model_mem[model_sel][l][b] = 0;
            end
            exp_lane.push_back(l);
            exp_bin.push_back(best_b);
            exp_count.push_back(best);
        end
        model_sel = 1 - model_sel;
        exp_his   = ~exp_his;
    endtask

    task automatic model_acq();
        model_acq_cnt++;
        if (model_acq_cnt == ACQ_NUM) begin
            model_acq_cnt = 0;
            model_close_frame();
        end
    endtask

    // one clock of stimulus, hit before acq_end in the model
    task automatic drive_cycle(input logic h, input int pix, input int bin, input logic a);
        hit       = h;
        hit_pixel = (LANE_BITS + 1)'(pix);
        hit_bin   = BIN_BITS'(bin);
        acq_end   = a;
        if (h) model_hit(pix, bin);
        if (a) model_acq();
        @(posedge clk);
        #STIM_DLY;
        hit     = 1'b0;
        acq_end = 1'b0;
        assert (his_num === exp_his) else
            stop_run($sformatf("** Error at %0d ns: his_num is %b, expected %b",
                               $time, his_num, exp_his));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 0, 0, 1'b0);
    endtask

    task automatic run_command(input string line);
        byte cmd;
        int  a1;
        int  a2;
        int  a3;
        a1 = 0;
        a2 = 0;
        a3 = 0;
        void'($sscanf(line, "%c %d %d %d", cmd, a1, a2, a3));
        case (cmd)
            "H": begin
                drive_cycle(1'b1, a1, a2, 1'b0);
                idle_cycles($urandom % 3);
            end
            "B": begin
                // hit together with acq_end
                drive_cycle(1'b1, a1, a2, 1'b1);
                idle_cycles($urandom % 3);
            end
            "A": begin
                drive_cycle(1'b0, 0, 0, 1'b1);
                idle_cycles($urandom % 3);
            end
            "R": repeat (a3) drive_cycle(1'b1, a1, a2, 1'b0);
            "G": idle_cycles(a1);
            "P": begin
                file_lane.push_back(a1);
                file_bin.push_back(a2);
                file_count.push_back(a3);
            end
            default: stop_run($sformatf("unknown command in hist_tests.txt: %s", line));
        endcase
    endtask

    // compare one report against model and test file
    task automatic check_report();
        if (file_lane.size() == 0) begin
            stop_run("a peak was reported but the test file has no P line left for it");
        end else begin
            assert (exp_lane[0] == file_lane[0] && exp_bin[0] == file_bin[0] &&
                    exp_count[0] == file_count[0]) else
                stop_run($sformatf({"** Error at %0d ns: model peak lane %0d bin %0d ",
                                    "count %0d, test file lane %0d bin %0d count %0d"},
                                   $time, exp_lane[0], exp_bin[0], exp_count[0],
                                   file_lane[0], file_bin[0], file_count[0]));
            assert (int'(peak_lane) == exp_lane[0] && int'(peak_bin) == exp_bin[0] &&
                    int'(peak_count) == exp_count[0]) else
                stop_run($sformatf({"** Error at %0d ns: DUT peak lane %0d bin %0d ",
                                    "count %0d, expected lane %0d bin %0d count %0d"},
                                   $time, peak_lane, peak_bin, peak_count,
                                   exp_lane[0], exp_bin[0], exp_count[0]));
            void'(exp_lane.pop_front());
            void'(exp_bin.pop_front());
            void'(exp_count.pop_front());
            void'(file_lane.pop_front());
            void'(file_bin.pop_front());
            void'(file_count.pop_front());
        end
    endtask

    // outputs sampled at the falling edge
    initial begin : report_checker
        int        waited;
        ro_state_t st;
        forever begin
            @(negedge clk);
            if (exp_lane.size() > 0) begin
                waited = 0;
                while (!peak_valid) begin
                    @(negedge clk);
                    waited++;
                    if (waited > PEAK_TIMEOUT) begin
                        st = u_dut.u_readout.state;
                        stop_run($sformatf("no peak report within %0d cycles, readout in %s",
                                           PEAK_TIMEOUT, st.name()));
                    end
                end
                check_report();
            end else begin
                assert (!peak_valid) else
                    stop_run($sformatf("** Error at %0d ns: peak_valid without a closed frame",
                                       $time));
            end
        end
    end

    initial begin : stimulus
        int    fd;
        int    waited;
        string line;
        void'($urandom(SEED));
        res       = 1'b0;
        hit       = 1'b0;
        hit_pixel = '0;
        hit_bin   = '0;
        acq_end   = 1'b0;
        exp_his   = 1'b0;
        model_sel     = 0;
        model_acq_cnt = 0;
        for (int b = 0; b < 2; b++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int i = 0; i < NUM_BINS; i++) begin
                    model_mem[b][l][i] = 0;
                end
            end
        end
        repeat (2) @(posedge clk);
        #STIM_DLY;
        res = 1'b1;
        fd = $fopen("hist_tests.txt", "r");
        if (fd == 0) stop_run("could not open hist_tests.txt for reading");
        while (!$feof(fd)) begin
            line = "";
            // blank and comment lines skipped
            if ($fgets(line, fd) > 0 && line[0] != "#" && line[0] != "\n") begin
                run_command(line);
            end
        end
        $fclose(fd);
        waited = 0;
        while (exp_lane.size() > 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) stop_run("the last frame's peak reports never came out");
        end
        if (file_lane.size() != 0) begin
            stop_run("the test file has P lines that no peak report matched");
        end else begin
            idle_cycles(4);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: hist_top.sv
`timescale 1ns/1ps

module hist_top import hist_pkg::*; #(
    parameter int NUM_LANES  = DEF_NUM_LANES,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int COUNT_BITS = DEF_COUNT_BITS,
    parameter int ACQ_NUM    = DEF_ACQ_NUM
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  hit,
    input  logic [LANE_BITS:0]    hit_pixel,
    input  logic [BIN_BITS-1:0]   hit_bin,
    input  logic                  acq_end,
    output logic                  his_num,
    output logic                  peak_valid,
    output logic [LANE_BITS-1:0]  peak_lane,
    output logic [BIN_BITS-1:0]   peak_bin,
    output logic [COUNT_BITS-1:0] peak_count
);

    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // dispatcher to lanes
    logic [NUM_LANES-1:0] lane_hit;
    logic [BIN_BITS-1:0]  lane_bin;
    logic                 frame_swap;

    // readout to lanes and back
    logic [BIN_BITS-1:0]             rd_bin;
    logic                            rd_clear;
    logic [NUM_LANES*COUNT_BITS-1:0] rd_count;

    hist_dispatch #(
        .NUM_LANES (NUM_LANES),
        .BIN_BITS  (BIN_BITS),
        .ACQ_NUM   (ACQ_NUM)
    ) u_dispatch (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_pixel  (hit_pixel),
        .hit_bin    (hit_bin),
        .acq_end    (acq_end),
        .lane_hit   (lane_hit),
        .lane_bin   (lane_bin),
        .frame_swap (frame_swap),
        .his_num    (his_num)
    );

    // one histogram per pixel, each owns a slice of rd_count
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        hist_lane #(
            .BIN_BITS   (BIN_BITS),
            .COUNT_BITS (COUNT_BITS)
        ) u_lane (
            .clk        (clk),
            .res        (res),
            .lane_hit   (lane_hit[g]),
            .lane_bin   (lane_bin),
            .frame_swap (frame_swap),
            .rd_bin     (rd_bin),
            .rd_clear   (rd_clear),
            .rd_count   (rd_count[g*COUNT_BITS +: COUNT_BITS])
        );
    end

    peak_readout #(
        .NUM_LANES  (NUM_LANES),
        .BIN_BITS   (BIN_BITS),
        .COUNT_BITS (COUNT_BITS)
    ) u_readout (
        .clk        (clk),
        .res        (res),
        .frame_swap (frame_swap),
        .rd_count   (rd_count),
        .rd_bin     (rd_bin),
        .rd_clear   (rd_clear),
        .peak_valid (peak_valid),
        .peak_lane  (peak_lane),
        .peak_bin   (peak_bin),
        .peak_count (peak_count)
    );

endmodule

// File: peak_readout.sv
`timescale 1ns/1ps

module peak_readout import hist_pkg::*; #(
    parameter int NUM_LANES  = DEF_NUM_LANES,
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int COUNT_BITS = DEF_COUNT_BITS
) (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            frame_swap,
    input  logic [NUM_LANES*COUNT_BITS-1:0] rd_count,
    output logic [BIN_BITS-1:0]             rd_bin,
    output logic                            rd_clear,
    output logic                            peak_valid,
    output logic [LANE_BITS-1:0]            peak_lane,
    output logic [BIN_BITS-1:0]             peak_bin,
    output logic [COUNT_BITS-1:0]           peak_count
);

    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [BIN_BITS-1:0]  BIN_LAST  = '1;
    localparam logic [LANE_BITS-1:0] LANE_LAST = LANE_BITS'(NUM_LANES - 1);

    ro_state_t state;

    // lane being reported
    logic [LANE_BITS-1:0] rep_idx;

    // running maximum per lane
    logic [COUNT_BITS-1:0] best_count [NUM_LANES];
    logic [BIN_BITS-1:0]   best_bin   [NUM_LANES];

    // every bin read during the scan is also cleared
    assign rd_clear = (state == RO_SCAN);

    // readout FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= RO_IDLE;
            rd_bin     <= '0;
            rep_idx    <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            case (state)
                RO_IDLE: begin
                    rd_bin  <= '0;
                    rep_idx <= '0;
                    // lanes flip on this same edge
                    if (frame_swap) begin
                        state <= RO_SCAN;
                    end
                end
                RO_SCAN: begin
                    rd_bin <= rd_bin + 1'b1;
                    if (rd_bin == BIN_LAST) begin
                        state <= RO_REPORT;
                    end
                end
                RO_REPORT: begin
                    // one lane per cycle, in lane order
                    peak_valid <= 1'b1;
                    rep_idx    <= rep_idx + 1'b1;
                    if (rep_idx == LANE_LAST) begin
                        state <= RO_IDLE;
                    end
                end
                default: begin
                    state <= RO_IDLE;
                end
            endcase
        end
    end

    // peak tracking
    // starts at bin 0 count 0, so an empty lane reports just that
    always_ff @(posedge clk) begin
        if (state == RO_IDLE && frame_swap) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                best_count[l] <= '0;
                best_bin[l]   <= '0;
            end
        end else if (state == RO_SCAN) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                // strictly greater, lowest bin wins a tie
                if (rd_count[l*COUNT_BITS +: COUNT_BITS] > best_count[l]) begin
                    best_count[l] <= rd_count[l*COUNT_BITS +: COUNT_BITS];
                    best_bin[l]   <= rd_bin;
                end
            end
        end
    end

    // report data, valid with peak_valid
    always_ff @(posedge clk) begin
        if (state == RO_REPORT) begin
            peak_lane  <= rep_idx;
            peak_bin   <= best_bin[rep_idx];
            peak_count <= best_count[rep_idx];
        end
    end

    // no back-pressure, a frame must outlast one drain
    a_swap_when_idle: assert property (
        @(posedge clk) disable iff (!res) frame_swap |-> (state == RO_IDLE)
    ) else $error("frame swap while the readout is still draining");

endmodule

// File: hist_lane.sv
`timescale 1ns/1ps

module hist_lane import hist_pkg::*; #(
    parameter int BIN_BITS   = DEF_BIN_BITS,
    parameter int COUNT_BITS = DEF_COUNT_BITS
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  lane_hit,
    input  logic [BIN_BITS-1:0]   lane_bin,
    input  logic                  frame_swap,
    input  logic [BIN_BITS-1:0]   rd_bin,
    input  logic                  rd_clear,
    output logic [COUNT_BITS-1:0] rd_count
);

    localparam int NUM_BINS = 2 ** BIN_BITS;
    localparam logic [COUNT_BITS-1:0] COUNT_MAX = '1;

    // two banks, one filling while the other drains
    logic [COUNT_BITS-1:0] mem [2][NUM_BINS];

    // bank currently taking hits
    logic bank_sel;
    // bank the readout sees
    logic idle_sel;

    // count at the hit bin in the active bank
    logic [COUNT_BITS-1:0] hit_count;
    logic                  hit_sat;

    assign idle_sel  = ~bank_sel;
    assign hit_count = mem[bank_sel][lane_bin];
    assign hit_sat   = (hit_count == COUNT_MAX);

    // readout port, idle bank only
    assign rd_count = mem[idle_sel][rd_bin];

    // bank select
    // a hit landing with the swap still uses the old bank,
    // it was sampled before the flip
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bank_sel <= 1'b0;
        end else if (frame_swap) begin
            bank_sel <= ~bank_sel;
        end
    end

    // histogram storage
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // both banks start empty
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < NUM_BINS; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            // read and clear on the idle side
            if (rd_clear) begin
                mem[idle_sel][rd_bin] <= '0;
            end
            // increment on the active side, stick at max
            if (lane_hit && !hit_sat) begin
                mem[bank_sel][lane_bin] <= hit_count + 1'b1;
            end
        end
    end

    // clear must not overlap a flip
    // otherwise it lands in the bank about to go active
    a_clear_no_swap: assert property (
        @(posedge clk) disable iff (!res) rd_clear |-> !frame_swap
    ) else $error("rd_clear while the banks swap");

endmodule

// File: hist_dispatch.sv
`timescale 1ns/1ps

module hist_dispatch import hist_pkg::*; #(
    parameter int NUM_LANES = DEF_NUM_LANES,
    parameter int BIN_BITS  = DEF_BIN_BITS,
    parameter int ACQ_NUM   = DEF_ACQ_NUM
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   hit,
    input  logic [LANE_BITS:0]     hit_pixel,
    input  logic [BIN_BITS-1:0]    hit_bin,
    input  logic                   acq_end,
    output logic [NUM_LANES-1:0]   lane_hit,
    output logic [BIN_BITS-1:0]    lane_bin,
    output logic                   frame_swap,
    output logic                   his_num
);

    // lane index width, pixel input carries one extra bit
    // so out of range pixels can be seen and dropped
    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int ACQ_BITS  = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;
    localparam logic [ACQ_BITS-1:0] ACQ_LAST = ACQ_BITS'(ACQ_NUM - 1);

    // acquisitions seen in the current frame
    logic [ACQ_BITS-1:0] acq_cnt;

    // one-hot lane enable, one cycle after the hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            lane_hit <= '0;
        end else begin
            lane_hit <= '0;
            // pixels at or past NUM_LANES are dropped here only
            if (hit && (hit_pixel < NUM_LANES)) begin
                lane_hit[hit_pixel[LANE_BITS-1:0]] <= 1'b1;
            end
        end
    end

    // bin travels alongside lane_hit
    always_ff @(posedge clk) begin
        if (hit) begin
            lane_bin <= hit_bin;
        end
    end

    // acquisition counter and frame swap
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acq_cnt    <= '0;
            frame_swap <= 1'b0;
            his_num    <= 1'b0;
        end else begin
            frame_swap <= 1'b0;
            if (acq_end) begin
                if (acq_cnt == ACQ_LAST) begin
                    // frame done, lanes flip banks next edge
                    acq_cnt    <= '0;
                    frame_swap <= 1'b1;
                    his_num    <= ~his_num;
                end else begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
            end
        end
    end

    // a hit reaches at most one lane per cycle
    a_lane_hit_onehot: assert property (
        @(posedge clk) disable iff (!res) $onehot0(lane_hit)
    ) else $error("lane_hit has more than one lane set");

endmodule

// File: hist_pkg.sv
// shared types and default sizes for the histogram subsystem
package hist_pkg;

    // readout FSM states
    // idle waits for a frame swap,
    // scan drains the idle banks,
    // report emits one peak per lane
    typedef enum logic [1:0] {
        RO_IDLE   = 2'd0,
        RO_SCAN   = 2'd1,
        RO_REPORT = 2'd2
    } ro_state_t;

    // number of pixel lanes, one histogram each
    localparam int DEF_NUM_LANES = 4;

    // timing bin address width
    // 4 bits gives 16 bins per histogram
    localparam int DEF_BIN_BITS = 4;

    // width of one bin count, saturates at all ones
    localparam int DEF_COUNT_BITS = 8;

    // acquisitions per frame
    // frame closes on the last acq_end strobe
    localparam int DEF_ACQ_NUM = 4;

    // drain length is 2**BIN_BITS scan cycles plus one report per lane.
    // a frame has to outlast that, nothing holds off the next swap

endpackage
